//--- hw/atetrisSettings_settings.svh
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Build constants for the Tetris board peripherals: RAM address widths,
// the MCLK divider and the scanline timing. Include wherever they are used
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef ATETRIS_SETTINGS_SVH
`define ATETRIS_SETTINGS_SVH

// RAM address widths
`define ATETRIS_WRAM_AW 12
`define ATETRIS_NVRAM_AW 9
`define ATETRIS_VRAM_AW 11
`define ATETRIS_PAL_AW 8

// MCLK cycles per bus slot, and the divider phase of the slot
`define ATETRIS_CE_DIV 8
`define ATETRIS_CE_PHASE 3

// Frames without a kick before the watchdog fires
`define ATETRIS_WDT_FRAMES 8

// IRQ pattern repeats every 64 lines of the active area
`define ATETRIS_IRQ_PERIOD 64
`define ATETRIS_IRQ_SET_LINE 48
`define ATETRIS_IRQ_CLR_LINE 16
`define ATETRIS_VBLANK_LINE 240

`endif

//--- hw/atetrisPkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared types of the Tetris board peripherals. Modules refer to them by
// scoped name, for example atetrisPkg::busReqT
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package atetrisPkg;

	// One byte access from the bus master
	typedef struct packed {
		logic [15:0] addr;
		logic        write;
		logic [7:0]  wdata;
	} busReqT;

	// One-hot target selects, valid for the cycle after acceptance
	typedef struct packed {
		logic wram;
		logic nvram;
		logic vramHi;
		logic vramLo;
		logic palette;
		logic inp0;
		logic inp1;
		logic wdtKick;
		logic irqAck;
	} chipSelT;

	// Pixel attributes carried past the character fetch
	typedef struct packed {
		// Upper nibble of the palette index
		logic [3:0] bank;
		// Which 4-bit pixel of the character word
		logic [1:0] nibSel;
	} pixStageT;

endpackage

//--- hw/atetrisBusDecode.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Address decoder of the CPU bus. Registers each accepted request and
// turns its address into one-hot chip selects for the next cycle
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module atetrisBusDecode (
	input  logic                MCLK,
	input  logic                RESET,
	input  atetrisPkg::busReqT  req_i,
	input  logic                accept_i,
	output atetrisPkg::chipSelT cs_o,
	output atetrisPkg::busReqT  reqReg_o
);

	atetrisPkg::chipSelT csNext;
	logic [15:0] addr;

	assign addr = req_i.addr;

	// Address map of the low 16 KB
	always_comb begin
		csNext.wram    = (addr[15:12] == 4'h0);
		csNext.vramHi  = (addr[15:12] == 4'h1) &  addr[0];
		csNext.vramLo  = (addr[15:12] == 4'h1) & ~addr[0];
		csNext.palette = (addr[15:10] == 6'b0010_00);
		csNext.nvram   = (addr[15:10] == 6'b0010_01);
		// Both input ports live in the $28xx block
		csNext.inp0    = (addr[15:10] == 6'b0010_10) & (addr[5:4] == 2'b00);
		csNext.inp1    = (addr[15:10] == 6'b0010_10) & (addr[5:4] == 2'b01);
		csNext.wdtKick = (addr[15:10] == 6'b0011_00);
		csNext.irqAck  = (addr[15:10] == 6'b0011_10);
	end

	always_ff @(posedge MCLK) begin
		if (RESET) begin
			cs_o <= '0;
		end else if (accept_i) begin
			cs_o <= csNext;
		end else begin
			cs_o <= '0;
		end
	end

	// Request held alongside the selects
	always_ff @(posedge MCLK) begin
		if (accept_i) begin
			reqReg_o <= req_i;
		end
	end

	// Address ranges must never overlap
	assert property (@(posedge MCLK) disable iff (RESET) $onehot0(cs_o))
		else $error("more than one target selected at %0t", $time);

endmodule

//--- hw/atetrisWorkRam.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Work RAM and NVRAM of the CPU. Writes land in the selected array, and
// read data appears one cycle after the chip select
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "atetrisSettings_settings.svh"

module atetrisWorkRam (
	input  logic                MCLK,
	input  atetrisPkg::chipSelT cs_i,
	input  atetrisPkg::busReqT  req_i,
	output logic [7:0]          rdata_o
);

	logic [7:0] wram [2**`ATETRIS_WRAM_AW];
	logic [7:0] nvram [2**`ATETRIS_NVRAM_AW];

	logic [`ATETRIS_WRAM_AW-1:0] wramAddr;
	logic [`ATETRIS_NVRAM_AW-1:0] nvramAddr;
	logic [7:0] wramQ;
	logic [7:0] nvramQ;
	logic nvSelQ;

	assign wramAddr = req_i.addr[`ATETRIS_WRAM_AW-1:0];
	// NVRAM mirrors through its 1 KB window
	assign nvramAddr = req_i.addr[`ATETRIS_NVRAM_AW-1:0];

	always_ff @(posedge MCLK) begin
		if (cs_i.wram && req_i.write) begin
			wram[wramAddr] <= req_i.wdata;
		end
		wramQ <= wram[wramAddr];
	end

	always_ff @(posedge MCLK) begin
		if (cs_i.nvram && req_i.write) begin
			nvram[nvramAddr] <= req_i.wdata;
		end
		nvramQ <= nvram[nvramAddr];
	end

	// Select follows the data by one cycle
	always_ff @(posedge MCLK) begin
		nvSelQ <= cs_i.nvram;
	end

	assign rdata_o = nvSelQ ? nvramQ : wramQ;

endmodule

//--- hw/atetrisIrqWatchdog.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Scanline IRQ and frame watchdog. Both sample VPOS once per bus slot;
// the CPU acknowledges the IRQ and kicks the watchdog with bus writes
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "atetrisSettings_settings.svh"

module atetrisIrqWatchdog (
	input  logic                MCLK,
	input  logic                RESET,
	input  logic                slotEn_i,
	input  logic [8:0]          vpos_i,
	input  atetrisPkg::chipSelT cs_i,
	input  atetrisPkg::busReqT  req_i,
	output logic                irq_o,
	output logic                watchdogReset_o
);

	logic [8:0] vposQ;
	logic [3:0] wdtCnt;
	logic lineStep;
	logic ackWr;
	logic kickWr;
	logic irqSetLine;
	logic irqClrLine;

	// A new line seen on a bus slot
	assign lineStep = slotEn_i && (vpos_i != vposQ);
	assign ackWr = cs_i.irqAck && req_i.write;
	assign kickWr = cs_i.wdtKick && req_i.write;

	// Lines 48, 112, 176, 240 set and 16, 80, 144, 208 clear
	assign irqSetLine = (vpos_i < 9'd256) &&
		((vpos_i % `ATETRIS_IRQ_PERIOD) == `ATETRIS_IRQ_SET_LINE);
	assign irqClrLine = (vpos_i < 9'd256) &&
		((vpos_i % `ATETRIS_IRQ_PERIOD) == `ATETRIS_IRQ_CLR_LINE);

	always_ff @(posedge MCLK) begin
		if (RESET) begin
			vposQ <= '0;
		end else if (slotEn_i) begin
			vposQ <= vpos_i;
		end
	end

	always_ff @(posedge MCLK) begin
		if (RESET) begin
			irq_o <= 1'b0;
		end else if (ackWr) begin
			irq_o <= 1'b0;
		end else if (lineStep) begin
			if (irqSetLine) begin
				irq_o <= 1'b1;
			end else if (irqClrLine) begin
				irq_o <= 1'b0;
			end
		end
	end

	// Counts frames; past the limit it parks at 14 so it wraps after two more
	always_ff @(posedge MCLK) begin
		if (RESET || kickWr) begin
			wdtCnt <= '0;
		end else if (lineStep && (vpos_i == 9'd0)) begin
			if (wdtCnt == 4'(`ATETRIS_WDT_FRAMES)) begin
				wdtCnt <= 4'd14;
			end else begin
				wdtCnt <= wdtCnt + 4'd1;
			end
		end
	end

	assign watchdogReset_o = wdtCnt[3];

	// A rise needs a set line in the active area and no acknowledge
	assert property (@(posedge MCLK) disable iff (RESET)
		$rose(irq_o) |-> $past(!ackWr && !vpos_i[8] && (vpos_i[5:0] == 6'd48)))
		else $error("IRQ rose off a set line or during acknowledge at %0t", $time);

endmodule

//--- hw/atetrisVideo.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Playfield video. Holds the two VRAM planes and the palette behind a CPU
// port, and turns HPOS/VPOS plus char ROM data into palette pixels
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "atetrisSettings_settings.svh"

module atetrisVideo (
	input  logic                MCLK,
	input  logic                RESET,
	input  logic                pixEn_i,
	input  logic [8:0]          hpos_i,
	input  logic [8:0]          vpos_i,
	input  atetrisPkg::chipSelT cs_i,
	input  atetrisPkg::busReqT  req_i,
	output logic [7:0]          rdata_o,
	output logic [15:0]         charAddr_o,
	input  logic [15:0]         charData_i,
	output logic [7:0]          pix_o,
	output logic                vblank_o
);

	logic [7:0] vramHi [2**`ATETRIS_VRAM_AW];
	logic [7:0] vramLo [2**`ATETRIS_VRAM_AW];
	logic [7:0] palette [2**`ATETRIS_PAL_AW];

	logic [`ATETRIS_VRAM_AW-1:0] cpuVAddr;
	logic [`ATETRIS_PAL_AW-1:0] cpuPAddr;
	logic [7:0] hiQ;
	logic [7:0] loQ;
	logic [7:0] palQ;
	logic hiSelQ;
	logic loSelQ;

	logic [`ATETRIS_VRAM_AW-1:0] tileAddr;
	logic [15:0] tileQ;
	// Pixel row and column inside the tile
	logic [5:0] s1PosQ;
	atetrisPkg::pixStageT s2Q;
	logic [3:0] nibble;
	logic [7:0] palIdxQ;

	// Odd addresses hit the high plane, even the low plane
	assign cpuVAddr = req_i.addr[`ATETRIS_VRAM_AW:1];
	assign cpuPAddr = req_i.addr[`ATETRIS_PAL_AW-1:0];

	always_ff @(posedge MCLK) begin
		if (cs_i.vramHi && req_i.write) begin
			vramHi[cpuVAddr] <= req_i.wdata;
		end
		if (cs_i.vramLo && req_i.write) begin
			vramLo[cpuVAddr] <= req_i.wdata;
		end
		hiQ <= vramHi[cpuVAddr];
		loQ <= vramLo[cpuVAddr];
		hiSelQ <= cs_i.vramHi;
		loSelQ <= cs_i.vramLo;
	end

	always_ff @(posedge MCLK) begin
		if (cs_i.palette && req_i.write) begin
			palette[cpuPAddr] <= req_i.wdata;
		end
		palQ <= palette[cpuPAddr];
	end

	assign rdata_o = hiSelQ ? hiQ : (loSelQ ? loQ : palQ);

	// Stage 1, tile fetch runs three pixels ahead of the display
	assign tileAddr = {vpos_i[7:3], hpos_i[8:3]};

	always_ff @(posedge MCLK) begin
		if (pixEn_i) begin
			tileQ <= {vramHi[tileAddr], vramLo[tileAddr]};
			s1PosQ <= {vpos_i[2:0], hpos_i[2:0]};
		end
	end

	// Stage 2, char word holds four pixels of one tile row
	always_ff @(posedge MCLK) begin
		if (pixEn_i) begin
			charAddr_o <= {tileQ[11:0], s1PosQ[5:3], s1PosQ[2]};
			s2Q.bank <= tileQ[15:12];
			s2Q.nibSel <= s1PosQ[1:0];
		end
	end

	// Stage 3, leftmost pixel in the top nibble
	always_comb begin
		case (s2Q.nibSel)
			2'd0: nibble = charData_i[15:12];
			2'd1: nibble = charData_i[11:8];
			2'd2: nibble = charData_i[7:4];
			default: nibble = charData_i[3:0];
		endcase
	end

	always_ff @(posedge MCLK) begin
		if (pixEn_i) begin
			palIdxQ <= {s2Q.bank, nibble};
		end
	end

	// Palette lookup; blank during reset
	always_ff @(posedge MCLK) begin
		if (RESET) begin
			pix_o <= '0;
		end else if (pixEn_i) begin
			pix_o <= palette[palIdxQ];
		end
	end

	assign vblank_o = (vpos_i >= 9'(`ATETRIS_VBLANK_LINE));

	// With pixel enables two MCLKs apart, the tile bank reaches the palette index
	assert property (@(posedge MCLK) disable iff (RESET)
		pixEn_i |-> ##2 (s2Q.bank === $past(tileQ[15:12], 2))
			##1 (palIdxQ[7:4] === $past(tileQ[15:12], 3)))
		else $error("palette bank out of step at %0t", $time);

endmodule

//--- hw/atetrisBoard.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Top level of the Tetris board peripherals. Divides MCLK into bus slots
// and pixel enables, decodes master requests and returns read data
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "atetrisSettings_settings.svh"

module atetrisBoard (
	input  logic               MCLK,
	input  logic               RESET,
	input  logic               reqValid_i,
	input  atetrisPkg::busReqT req_i,
	output logic               reqReady_o,
	output logic               rdValid_o,
	output logic [7:0]         rdData_o,
	input  logic [10:0]        inputs_i,
	input  logic [8:0]         hpos_i,
	input  logic [8:0]         vpos_i,
	output logic               pixEn_o,
	output logic [15:0]        charAddr_o,
	input  logic [15:0]        charData_i,
	output logic [7:0]         pix_o,
	output logic               irq_o,
	output logic               watchdogReset_o
);

	localparam int DivW = $clog2(`ATETRIS_CE_DIV);

	logic [DivW-1:0] clkDiv;
	logic slotEn;
	logic accept;
	atetrisPkg::chipSelT cs;
	atetrisPkg::chipSelT csQ;
	atetrisPkg::busReqT reqReg;
	logic [7:0] ramData;
	logic [7:0] vidData;
	logic [7:0] port0;
	logic [7:0] port1;
	logic [7:0] portQ;
	logic vblank;
	logic readPendQ;

	always_ff @(posedge MCLK) begin
		if (RESET || (clkDiv == DivW'(`ATETRIS_CE_DIV - 1))) begin
			clkDiv <= '0;
		end else begin
			clkDiv <= clkDiv + 1'b1;
		end
	end

	assign slotEn = (clkDiv == DivW'(`ATETRIS_CE_PHASE));
	assign pixEn_o = ~clkDiv[0];
	assign reqReady_o = slotEn;
	assign accept = reqValid_i && reqReady_o;

	atetrisBusDecode uDecode (.MCLK(MCLK), .RESET(RESET), .req_i(req_i),
		.accept_i(accept), .cs_o(cs), .reqReg_o(reqReg));

	atetrisWorkRam uWorkRam (.MCLK(MCLK), .cs_i(cs), .req_i(reqReg), .rdata_o(ramData));

	atetrisIrqWatchdog uIrqWdt (.MCLK(MCLK), .RESET(RESET), .slotEn_i(slotEn),
		.vpos_i(vpos_i), .cs_i(cs), .req_i(reqReg), .irq_o(irq_o),
		.watchdogReset_o(watchdogReset_o));

	atetrisVideo uVideo (.MCLK(MCLK), .RESET(RESET), .pixEn_i(pixEn_o), .hpos_i(hpos_i),
		.vpos_i(vpos_i), .cs_i(cs), .req_i(reqReg), .rdata_o(vidData),
		.charAddr_o(charAddr_o), .charData_i(charData_i), .pix_o(pix_o),
		.vblank_o(vblank));

	// Port 0 is self-test, VBLANK, four unused high bits, then coin 2 and coin 1
	assign port0 = {inputs_i[10], vblank, 4'b1111, inputs_i[8], inputs_i[9]};
	assign port1 = inputs_i[7:0];

	// Port byte latched like the RAM read data
	always_ff @(posedge MCLK) begin
		portQ <= cs.inp1 ? port1 : port0;
	end

	always_ff @(posedge MCLK) begin
		if (RESET) begin
			readPendQ <= 1'b0;
			rdValid_o <= 1'b0;
			csQ <= '0;
		end else begin
			readPendQ <= accept && !req_i.write;
			rdValid_o <= readPendQ;
			csQ <= cs;
		end
	end

	always_comb begin
		if (csQ.wram || csQ.nvram) begin
			rdData_o = ramData;
		end else if (csQ.vramHi || csQ.vramLo || csQ.palette) begin
			rdData_o = vidData;
		end else if (csQ.inp0 || csQ.inp1) begin
			rdData_o = portQ;
		end else begin
			rdData_o = 8'h00;
		end
	end

endmodule

//--- tests/atetrisBoardTb.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench of the Tetris board peripherals. A bus master walks a table of
// reads and writes, then checks the input ports, IRQ, pixels and watchdog
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "atetrisSettings_settings.svh"

module atetrisBoardTb;

	typedef struct packed {
		logic [15:0] addr;
		logic        write;
		logic [7:0]  data;
		logic [7:0]  expData;
	} stepT;

	// Short raster lines keep a frame cheap
	localparam int HTotal = 32;
	localparam int VTotal = 262;
	localparam int FrameCycles = HTotal * 2 * VTotal;
	localparam int TileWrites = 2 * 32 * (HTotal / 8);
	localparam logic [10:0] InpA = 11'h5A3;

	logic MCLK;
	logic RESET;
	logic reqValid;
	atetrisPkg::busReqT req;
	logic reqReady;
	logic rdValid;
	logic [7:0] rdData;
	logic [10:0] inputs;
	logic [8:0] hpos;
	logic [8:0] vpos;
	logic pixEn;
	logic [15:0] charAddr;
	logic [15:0] charData;
	logic [7:0] pix;
	logic irq;
	logic wdtRst;

	stepT steps[$];
	int errors = 0;
	int cycles = 0;
	int cycleLimit;
	int unsigned seedDummy;
	logic rasterRun = 1'b0;
	logic [8:0] holdV = 9'd100;
	logic [3:0] charNib = 4'h0;

	atetrisBoard DUT (.MCLK(MCLK), .RESET(RESET), .reqValid_i(reqValid), .req_i(req),
		.reqReady_o(reqReady), .rdValid_o(rdValid), .rdData_o(rdData), .inputs_i(inputs),
		.hpos_i(hpos), .vpos_i(vpos), .pixEn_o(pixEn), .charAddr_o(charAddr),
		.charData_i(charData), .pix_o(pix), .irq_o(irq), .watchdogReset_o(wdtRst));

	// Char ROM with the same nibble in every pixel
	assign charData = {4{charNib}};

	initial begin
		MCLK = 1'b0;
		forever #10 MCLK = ~MCLK;
	end

	// Raster counter, stepping one pixel per pixel enable
	initial begin
		hpos = '0;
		vpos = '0;
		forever begin
			@(posedge MCLK);
			#2;
			if (!rasterRun) begin
				hpos = '0;
				vpos = holdV;
			end else if (pixEn) begin
				if (hpos == 9'(HTotal - 1)) begin
					hpos = '0;
					vpos = (vpos == 9'(VTotal - 1)) ? 9'd0 : vpos + 9'd1;
				end else begin
					hpos = hpos + 9'd1;
				end
			end
		end
	end

	initial begin
		@(posedge MCLK);
		cycleLimit = (steps.size() + TileWrites + 40) * 16 + 28 * FrameCycles;
		while (cycles < cycleLimit) begin
			@(posedge MCLK);
			cycles++;
		end
		$display("Timeout: run reached %0d cycles with %0d errors so far", cycles, errors);
		$display("Errors found");
		$finish;
	end

	// Self-test, VBLANK, four unused ones, coin 2, coin 1
	function automatic logic [7:0] port0Byte(input logic [10:0] inp, input logic vb);
		return {inp[10], vb, 4'b1111, inp[8], inp[9]};
	endfunction

	task automatic reportMismatch(input string what, input logic [15:0] got,
		input logic [15:0] exp);
		errors++;
		$display("mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
	endtask

	task automatic addStep(input logic [15:0] a, input logic w, input logic [7:0] d,
		input logic [7:0] e);
		stepT s;
		s = '{addr: a, write: w, data: d, expData: e};
		steps.push_back(s);
	endtask

	task automatic buildTable();
		logic [7:0] d [7];
		for (int i = 0; i < 7; i++) begin
			d[i] = 8'($urandom);
		end
		addStep(16'h0000, 1'b1, d[0], 8'h00);
		addStep(16'h0FFF, 1'b1, d[1], 8'h00);
		addStep(16'h2400, 1'b1, d[2], 8'h00);
		addStep(16'h25FF, 1'b1, d[3], 8'h00);
		addStep(16'h1001, 1'b1, d[4], 8'h00);
		addStep(16'h1FFE, 1'b1, d[5], 8'h00);
		addStep(16'h2005, 1'b1, d[6], 8'h00);
		addStep(16'h0000, 1'b0, 8'h00, d[0]);
		addStep(16'h0FFF, 1'b0, 8'h00, d[1]);
		addStep(16'h2400, 1'b0, 8'h00, d[2]);
		addStep(16'h25FF, 1'b0, 8'h00, d[3]);
		// NVRAM and palette mirror inside their windows
		addStep(16'h2600, 1'b0, 8'h00, d[2]);
		addStep(16'h1001, 1'b0, 8'h00, d[4]);
		addStep(16'h1FFE, 1'b0, 8'h00, d[5]);
		addStep(16'h2005, 1'b0, 8'h00, d[6]);
		addStep(16'h2305, 1'b0, 8'h00, d[6]);
		addStep(16'h3400, 1'b0, 8'h00, 8'h00);
		addStep(16'h2C00, 1'b0, 8'h00, 8'h00);
		addStep(16'h2820, 1'b0, 8'h00, 8'h00);
		addStep(16'h3000, 1'b0, 8'h00, 8'h00);
		addStep(16'h2800, 1'b0, 8'h00, port0Byte(InpA, 1'b0));
		addStep(16'h2810, 1'b0, 8'h00, InpA[7:0]);
	endtask

	// Holds the request until a slot accepts it
	task automatic issueRequest(input logic [15:0] a, input logic w, input logic [7:0] d);
		@(posedge MCLK);
		#2;
		req = '{addr: a, write: w, wdata: d};
		reqValid = 1'b1;
		while (!reqReady) begin
			@(posedge MCLK);
			#2;
		end
		@(posedge MCLK);
		#2;
		reqValid = 1'b0;
	endtask

	task automatic busWrite(input logic [15:0] a, input logic [7:0] d);
		issueRequest(a, 1'b1, d);
	endtask

	task automatic busRead(input logic [15:0] a, output logic [7:0] d);
		issueRequest(a, 1'b0, 8'h00);
		while (!rdValid) begin
			@(posedge MCLK);
			#2;
		end
		d = rdData;
	endtask

	task automatic waitLine(input logic [8:0] line);
		@(negedge MCLK);
		while (vpos !== line) begin
			@(negedge MCLK);
		end
	endtask

	task automatic waitFrame();
		waitLine(9'd0);
		waitLine(9'd1);
	endtask

	task automatic checkPorts();
		logic [8:0] lines [4];
		logic [7:0] got;
		lines = '{9'd100, 9'd239, 9'd241, 9'd261};
		@(posedge MCLK);
		#2;
		inputs = 11'h2DC;
		foreach (lines[i]) begin
			@(negedge MCLK);
			holdV = lines[i];
			busRead(16'h2800, got);
			if (got !== port0Byte(inputs, lines[i] >= 9'd240)) begin
				reportMismatch("port 0", got, port0Byte(inputs, lines[i] >= 9'd240));
			end
		end
		busRead(16'h2810, got);
		if (got !== inputs[7:0]) begin
			reportMismatch("port 1", got, inputs[7:0]);
		end
	endtask

	task automatic checkIrq();
		@(negedge MCLK);
		holdV = 9'd40;
		repeat (2) @(negedge MCLK);
		rasterRun = 1'b1;
		waitLine(9'd46);
		if (irq !== 1'b0) reportMismatch("irq before line 48", irq, 0);
		waitLine(9'd50);
		if (irq !== 1'b1) reportMismatch("irq after line 48", irq, 1);
		waitLine(9'd84);
		if (irq !== 1'b0) reportMismatch("irq after line 80", irq, 0);
		waitLine(9'd114);
		if (irq !== 1'b1) reportMismatch("irq after line 112", irq, 1);
		busWrite(16'h3800, 8'h00);
		repeat (2) @(negedge MCLK);
		if (irq !== 1'b0) reportMismatch("irq after acknowledge", irq, 0);
		waitLine(9'd120);
		if (irq !== 1'b0) reportMismatch("irq later in the band", irq, 0);
	endtask

	task automatic checkPixels();
		logic [3:0] bank;
		logic [3:0] nib;
		logic [11:0] code;
		logic [7:0] palVal;
		logic lastEn;
		int tile;
		bank = 4'($urandom);
		nib = 4'($urandom);
		code = 12'($urandom);
		palVal = 8'($urandom);
		@(posedge MCLK);
		#2;
		charNib = nib;
		// Only the visible tile columns are filled
		for (int row = 0; row < 32; row++) begin
			for (int col = 0; col < HTotal / 8; col++) begin
				tile = row * 64 + col;
				busWrite(16'h1001 + 16'(2 * tile), {bank, code[11:8]});
				busWrite(16'h1000 + 16'(2 * tile), code[7:0]);
			end
		end
		busWrite({8'h20, bank, nib}, palVal);
		repeat (HTotal * 4) @(negedge MCLK);
		lastEn = pixEn;
		for (int i = 0; i < 2 * HTotal; i++) begin
			@(negedge MCLK);
			if (pix !== palVal) reportMismatch("pixel", pix, palVal);
			// Tile code sits above the row and column bits of the char address
			if (charAddr[15:4] !== code) reportMismatch("char address", charAddr[15:4], code);
			if (pixEn === lastEn) reportMismatch("pixel enable", pixEn, !lastEn);
			lastEn = pixEn;
		end
	endtask

	task automatic checkWatchdog();
		logic expWdt;
		busWrite(16'h3000, 8'h00);
		for (int round = 0; round < 3; round++) begin
			for (int f = 0; f < 4; f++) begin
				waitFrame();
				if (wdtRst !== 1'b0) reportMismatch("watchdog with kicks", wdtRst, 0);
			end
			busWrite(16'h3000, 8'h00);
		end
		// High from frame 8 until the counter wraps
		for (int f = 1; f <= 11; f++) begin
			waitFrame();
			expWdt = (f >= 8) && (f <= 10);
			if (wdtRst !== expWdt) reportMismatch("watchdog without kicks", wdtRst, expWdt);
		end
	endtask

	initial begin
		logic [7:0] got;
		RESET = 1'b1;
		reqValid = 1'b0;
		req = '0;
		inputs = InpA;
		seedDummy = $urandom(32'h794f_b4c3);
		buildTable();
		repeat (4) @(posedge MCLK);
		#2;
		RESET = 1'b0;
		if ({reqReady, rdValid, irq, wdtRst} !== 4'b0000) begin
			reportMismatch("outputs after reset", {reqReady, rdValid, irq, wdtRst}, 0);
		end
		foreach (steps[i]) begin
			if (steps[i].write) begin
				busWrite(steps[i].addr, steps[i].data);
			end else begin
				busRead(steps[i].addr, got);
				if (got !== steps[i].expData) reportMismatch("read", got, steps[i].expData);
			end
		end
		checkPorts();
		checkIrq();
		checkPixels();
		checkWatchdog();
		$display("Finished: %0d errors in %0d cycles", errors, cycles);
		if (errors == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule

//--- verilog.f
+incdir+hw
hw/atetrisPkg.sv
hw/atetrisBusDecode.sv
hw/atetrisWorkRam.sv
hw/atetrisIrqWatchdog.sv
hw/atetrisVideo.sv
hw/atetrisBoard.sv
tests/atetrisBoardTb.sv

//--- Bender.yml
package:
  name: atetris_board

export_include_dirs:
  - hw

sources:
  - files:
      - hw/atetrisPkg.sv
      - hw/atetrisBusDecode.sv
      - hw/atetrisWorkRam.sv
      - hw/atetrisIrqWatchdog.sv
      - hw/atetrisVideo.sv
      - hw/atetrisBoard.sv
  - target: test
    include_dirs:
      - hw
    files:
      - tests/atetrisBoardTb.sv
